//--- design/sched_pkg.sv
// ===========================================================================
// shared definitions for the single-issue scheduler front end
// widths, exception codes, instruction and unit classes, operation encodings
// modules pull these in with a wildcard import in their header
// ===========================================================================

`default_nettype none

package sched_pkg;

  // physical register file and free list
  localparam int PHYS_REG_NUM = 64;
  localparam int PREG_W       = $clog2(PHYS_REG_NUM);
  localparam int FREE_DEPTH   = 32;
  localparam int FREE_PTR_W   = $clog2(FREE_DEPTH);
  localparam int FREE_CNT_W   = $clog2(FREE_DEPTH + 1);
  localparam int ARCH_REG_W   = 5;
  localparam int UNIT_NUM     = 4;

  typedef logic [PREG_W-1:0] preg_t;

  // ========================================================================
  // exception codes
  // ========================================================================
  localparam int                ECODE_W   = 6;
  localparam logic [ECODE_W-1:0] ECODE_INT = 6'h00;
  localparam logic [ECODE_W-1:0] ECODE_SYS = 6'h0B;
  localparam logic [ECODE_W-1:0] ECODE_BRK = 6'h0C;
  localparam logic [ECODE_W-1:0] ECODE_INE = 6'h0D;
  localparam logic [ECODE_W-1:0] ECODE_IPE = 6'h0E;

  // cacop with this selector in code[4:3] is legal in user mode
  localparam logic [1:0] CACOP_USER_SEL = 2'd2;
  localparam logic [1:0] PLV_USER       = 2'd3;

  // ========================================================================
  // instruction classes and operation encodings
  // ========================================================================
  typedef enum logic [2:0] {
    INSTR_ALU, INSTR_MDU, INSTR_MEM, INSTR_BR, INSTR_MISC, INSTR_PRIV
  } instr_type_e;

  typedef enum logic [1:0] {
    UNIT_ALU, UNIT_MDU, UNIT_MEM, UNIT_MISC
  } unit_e;

  typedef enum logic [3:0] {
    ALU_OP_ADD, ALU_OP_SUB, ALU_OP_SLT, ALU_OP_SLTU, ALU_OP_AND, ALU_OP_OR,
    ALU_OP_NOR, ALU_OP_XOR, ALU_OP_SLL, ALU_OP_SRL, ALU_OP_SRA, ALU_OP_LUI
  } alu_op_e;

  typedef enum logic [3:0] {
    MEM_OP_LB, MEM_OP_LH, MEM_OP_LW, MEM_OP_LBU, MEM_OP_LHU, MEM_OP_SB,
    MEM_OP_SH, MEM_OP_SW, MEM_OP_LL, MEM_OP_SC, MEM_OP_PRELD, MEM_OP_CACOP,
    MEM_OP_DBAR, MEM_OP_IBAR
  } mem_op_e;

  typedef enum logic [3:0] {
    MISC_OP_SYSCALL, MISC_OP_BREAK, MISC_OP_ERTN, MISC_OP_IDLE, MISC_OP_RDCNT,
    MISC_OP_JIRL, MISC_OP_B, MISC_OP_BL, MISC_OP_BEQ, MISC_OP_BNE
  } misc_op_e;

  // one operation field, decoded per instruction type
  typedef union packed {
    alu_op_e  alu_op;
    mem_op_e  mem_op;
    misc_op_e misc_op;
  } op_u_t;

endpackage

`default_nettype wire

//--- design/phys_free_list.sv
// ===========================================================================
// circular list of free physical register numbers
// reset loads the upper half of the register file in ascending order
// head is allocated on alloc_i, freed registers are appended at the tail
// ===========================================================================

`timescale 1ns/1ps
`default_nettype none

module phys_free_list import sched_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  alloc_i,
  input  logic  free_valid_i,
  input  preg_t free_preg_i,
  output preg_t head_preg_o,
  output logic  not_empty_o
);

  preg_t                 free_mem [FREE_DEPTH];
  logic [FREE_PTR_W-1:0] head_ptr;
  logic [FREE_PTR_W-1:0] tail_ptr;
  logic [FREE_CNT_W-1:0] free_cnt;

  // list contents, preset so registers 32..63 are free out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < FREE_DEPTH; i++) begin
        free_mem[i] <= preg_t'(PHYS_REG_NUM - FREE_DEPTH + i);
      end
    end else if (free_valid_i) begin
      free_mem[tail_ptr] <= free_preg_i;
    end
  end

  // pointers wrap naturally at FREE_DEPTH
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_ptr <= '0;
      tail_ptr <= '0;
    end else begin
      if (alloc_i) begin
        head_ptr <= head_ptr + 1'b1;
      end
      if (free_valid_i) begin
        tail_ptr <= tail_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      free_cnt <= FREE_CNT_W'(FREE_DEPTH);
    end else begin
      case ({alloc_i, free_valid_i})
        2'b10:   free_cnt <= free_cnt - 1'b1;
        2'b01:   free_cnt <= free_cnt + 1'b1;
        default: free_cnt <= free_cnt;
      endcase
    end
  end

  // a freed register shows up here one cycle after its strobe
  assign head_preg_o = free_mem[head_ptr];
  assign not_empty_o = (free_cnt != '0);

endmodule

`default_nettype wire

//--- design/alloc_stage.sv
// ===========================================================================
// allocation stage of the scheduler
// accepts one request per cycle while a free register exists, takes the
// destination register from the free list and registers stage one
// ===========================================================================

`timescale 1ns/1ps
`default_nettype none

module alloc_stage import sched_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_valid_i,
  input  logic [31:0]           req_pc_i,
  input  instr_type_e           req_type_i,
  input  op_u_t                 req_op_i,
  input  logic                  req_invalid_i,
  input  logic                  req_fetch_excp_i,
  input  logic [ECODE_W-1:0]    req_fetch_ecode_i,
  input  logic [ARCH_REG_W-1:0] req_arch_dest_i,
  input  logic [4:0]            req_cacop_code_i,
  input  logic                  csr_has_int_i,
  input  logic [1:0]            csr_plv_i,
  input  logic                  free_valid_i,
  input  preg_t                 free_preg_i,
  output logic                  ready_o,
  output logic                  s1_valid_o,
  output logic [31:0]           s1_pc_o,
  output instr_type_e           s1_type_o,
  output op_u_t                 s1_op_o,
  output logic                  s1_invalid_o,
  output logic                  s1_fetch_excp_o,
  output logic [ECODE_W-1:0]    s1_fetch_ecode_o,
  output logic [ARCH_REG_W-1:0] s1_arch_dest_o,
  output logic [4:0]            s1_cacop_code_o,
  output logic                  s1_has_int_o,
  output logic [1:0]            s1_plv_o,
  output preg_t                 s1_pdest_o
);

  logic  fl_not_empty;
  logic  accept;
  logic  alloc;
  preg_t fl_head;

  phys_free_list u_free_list (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_i      (alloc),
    .free_valid_i (free_valid_i),
    .free_preg_i  (free_preg_i),
    .head_preg_o  (fl_head),
    .not_empty_o  (fl_not_empty)
  );

  // faulting, invalid and r0-writing requests leave the list alone
  assign ready_o = fl_not_empty;
  assign accept  = req_valid_i & fl_not_empty;
  assign alloc   = accept & ~req_fetch_excp_i & ~req_invalid_i & (|req_arch_dest_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_o <= 1'b0;
    end else begin
      s1_valid_o <= accept;
    end
  end

  // stage one payload, CSR state sampled together with the request
  always_ff @(posedge clk) begin
    if (accept) begin
      s1_pc_o          <= req_pc_i;
      s1_type_o        <= req_type_i;
      s1_op_o          <= req_op_i;
      s1_invalid_o     <= req_invalid_i;
      s1_fetch_excp_o  <= req_fetch_excp_i;
      s1_fetch_ecode_o <= req_fetch_ecode_i;
      s1_arch_dest_o   <= req_arch_dest_i;
      s1_cacop_code_o  <= req_cacop_code_i;
      s1_has_int_o     <= csr_has_int_i;
      s1_plv_o         <= csr_plv_i;
      s1_pdest_o       <= alloc ? fl_head : '0;
    end
  end

endmodule

`default_nettype wire

//--- design/excp_check.sv
// ===========================================================================
// exception decision for the instruction held in stage one
// purely combinational, priority INT > fetch exception > INE > IPE/SYS/BRK
// ===========================================================================

`timescale 1ns/1ps
`default_nettype none

module excp_check import sched_pkg::*; (
  input  instr_type_e        s1_type_i,
  input  op_u_t              s1_op_i,
  input  logic               s1_invalid_i,
  input  logic               s1_fetch_excp_i,
  input  logic [ECODE_W-1:0] s1_fetch_ecode_i,
  input  logic [4:0]         s1_cacop_code_i,
  input  logic               s1_has_int_i,
  input  logic [1:0]         s1_plv_i,
  output logic               excp_valid_o,
  output logic [ECODE_W-1:0] ecode_o
);

  logic priv_instr;
  logic syscall_instr;
  logic break_instr;

  // cacop counts as privileged unless it selects the user-mode class
  assign priv_instr = (s1_type_i == INSTR_PRIV) |
                      ((s1_type_i == INSTR_MEM) &
                       (s1_op_i.mem_op == MEM_OP_CACOP) &
                       (s1_cacop_code_i[4:3] != CACOP_USER_SEL));

  assign syscall_instr = (s1_type_i == INSTR_MISC) &
                         (s1_op_i.misc_op == MISC_OP_SYSCALL);
  assign break_instr   = (s1_type_i == INSTR_MISC) &
                         (s1_op_i.misc_op == MISC_OP_BREAK);

  always_comb begin
    excp_valid_o = 1'b1;
    ecode_o      = ECODE_INT;
    if (s1_has_int_i) begin
      ecode_o = ECODE_INT;
    end else if (s1_fetch_excp_i) begin
      // keep the code raised at fetch
      ecode_o = s1_fetch_ecode_i;
    end else if (s1_invalid_i) begin
      ecode_o = ECODE_INE;
    end else if (priv_instr && (s1_plv_i == PLV_USER)) begin
      ecode_o = ECODE_IPE;
    end else if (syscall_instr) begin
      ecode_o = ECODE_SYS;
    end else if (break_instr) begin
      ecode_o = ECODE_BRK;
    end else begin
      excp_valid_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- design/issue_route.sv
// ===========================================================================
// record and issue stage
// registers one reorder-buffer record per valid instruction and a one-hot
// issue strobe for its unit class when no exception was raised
// ===========================================================================

`timescale 1ns/1ps
`default_nettype none

module issue_route import sched_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  s1_valid_i,
  input  logic [31:0]           s1_pc_i,
  input  instr_type_e           s1_type_i,
  input  op_u_t                 s1_op_i,
  input  logic [ARCH_REG_W-1:0] s1_arch_dest_i,
  input  preg_t                 s1_pdest_i,
  input  logic                  excp_valid_i,
  input  logic [ECODE_W-1:0]    ecode_i,
  output logic                  rob_valid_o,
  output logic [31:0]           rob_pc_o,
  output instr_type_e           rob_type_o,
  output logic [ARCH_REG_W-1:0] rob_arch_dest_o,
  output preg_t                 rob_pdest_o,
  output logic                  rob_excp_valid_o,
  output logic [ECODE_W-1:0]    rob_ecode_o,
  output logic [UNIT_NUM-1:0]   issue_valid_o,
  output logic [31:0]           issue_pc_o,
  output op_u_t                 issue_op_o,
  output preg_t                 issue_pdest_o,
  output logic                  issue_dest_valid_o
);

  unit_e                unit;
  logic                 issue_en;
  logic [UNIT_NUM-1:0]  issue_sel;

  // branch, misc and privileged work all goes to the misc unit
  always_comb begin
    case (s1_type_i)
      INSTR_ALU: unit = UNIT_ALU;
      INSTR_MDU: unit = UNIT_MDU;
      INSTR_MEM: unit = UNIT_MEM;
      default:   unit = UNIT_MISC;
    endcase
  end

  assign issue_en  = s1_valid_i & ~excp_valid_i;
  assign issue_sel = issue_en ? (UNIT_NUM'(1) << unit) : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rob_valid_o      <= 1'b0;
      rob_excp_valid_o <= 1'b0;
      issue_valid_o    <= '0;
    end else begin
      rob_valid_o      <= s1_valid_i;
      rob_excp_valid_o <= s1_valid_i & excp_valid_i;
      issue_valid_o    <= issue_sel;
    end
  end

  // ========================================================================
  // payloads
  // ========================================================================
  always_ff @(posedge clk) begin
    if (s1_valid_i) begin
      rob_pc_o        <= s1_pc_i;
      rob_type_o      <= s1_type_i;
      rob_arch_dest_o <= s1_arch_dest_i;
      rob_pdest_o     <= s1_pdest_i;
      rob_ecode_o     <= ecode_i;
    end
    if (issue_en) begin
      issue_pc_o         <= s1_pc_i;
      issue_op_o         <= s1_op_i;
      issue_pdest_o      <= s1_pdest_i;
      issue_dest_valid_o <= |s1_arch_dest_i;
    end
  end

endmodule

`default_nettype wire

//--- design/sched_top.sv
// ===========================================================================
// top level of the scheduler front end
// request -> allocation stage -> exception check -> record and issue
// a request accepted at edge k shows its record after edge k+1
// ===========================================================================

`timescale 1ns/1ps
`default_nettype none

module sched_top import sched_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_valid_i,
  input  logic [31:0]           req_pc_i,
  input  instr_type_e           req_type_i,
  input  op_u_t                 req_op_i,
  input  logic                  req_invalid_i,
  input  logic                  req_fetch_excp_i,
  input  logic [ECODE_W-1:0]    req_fetch_ecode_i,
  input  logic [ARCH_REG_W-1:0] req_arch_dest_i,
  input  logic [4:0]            req_cacop_code_i,
  input  logic                  csr_has_int_i,
  input  logic [1:0]            csr_plv_i,
  input  logic                  free_valid_i,
  input  preg_t                 free_preg_i,
  output logic                  ready_o,
  output logic                  rob_valid_o,
  output logic [31:0]           rob_pc_o,
  output instr_type_e           rob_type_o,
  output logic [ARCH_REG_W-1:0] rob_arch_dest_o,
  output preg_t                 rob_pdest_o,
  output logic                  rob_excp_valid_o,
  output logic [ECODE_W-1:0]    rob_ecode_o,
  output logic [UNIT_NUM-1:0]   issue_valid_o,
  output logic [31:0]           issue_pc_o,
  output op_u_t                 issue_op_o,
  output preg_t                 issue_pdest_o,
  output logic                  issue_dest_valid_o
);

  // stage one
  logic                  s1_valid;
  logic [31:0]           s1_pc;
  instr_type_e           s1_type;
  op_u_t                 s1_op;
  logic                  s1_invalid;
  logic                  s1_fetch_excp;
  logic [ECODE_W-1:0]    s1_fetch_ecode;
  logic [ARCH_REG_W-1:0] s1_arch_dest;
  logic [4:0]            s1_cacop_code;
  logic                  s1_has_int;
  logic [1:0]            s1_plv;
  preg_t                 s1_pdest;

  // exception decision
  logic                  excp_valid;
  logic [ECODE_W-1:0]    ecode;

  alloc_stage u_alloc (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_valid_i       (req_valid_i),
    .req_pc_i          (req_pc_i),
    .req_type_i        (req_type_i),
    .req_op_i          (req_op_i),
    .req_invalid_i     (req_invalid_i),
    .req_fetch_excp_i  (req_fetch_excp_i),
    .req_fetch_ecode_i (req_fetch_ecode_i),
    .req_arch_dest_i   (req_arch_dest_i),
    .req_cacop_code_i  (req_cacop_code_i),
    .csr_has_int_i     (csr_has_int_i),
    .csr_plv_i         (csr_plv_i),
    .free_valid_i      (free_valid_i),
    .free_preg_i       (free_preg_i),
    .ready_o           (ready_o),
    .s1_valid_o        (s1_valid),
    .s1_pc_o           (s1_pc),
    .s1_type_o         (s1_type),
    .s1_op_o           (s1_op),
    .s1_invalid_o      (s1_invalid),
    .s1_fetch_excp_o   (s1_fetch_excp),
    .s1_fetch_ecode_o  (s1_fetch_ecode),
    .s1_arch_dest_o    (s1_arch_dest),
    .s1_cacop_code_o   (s1_cacop_code),
    .s1_has_int_o      (s1_has_int),
    .s1_plv_o          (s1_plv),
    .s1_pdest_o        (s1_pdest)
  );

  excp_check u_excp (
    .s1_type_i        (s1_type),
    .s1_op_i          (s1_op),
    .s1_invalid_i     (s1_invalid),
    .s1_fetch_excp_i  (s1_fetch_excp),
    .s1_fetch_ecode_i (s1_fetch_ecode),
    .s1_cacop_code_i  (s1_cacop_code),
    .s1_has_int_i     (s1_has_int),
    .s1_plv_i         (s1_plv),
    .excp_valid_o     (excp_valid),
    .ecode_o          (ecode)
  );

  issue_route u_issue (
    .clk                (clk),
    .rst_n              (rst_n),
    .s1_valid_i         (s1_valid),
    .s1_pc_i            (s1_pc),
    .s1_type_i          (s1_type),
    .s1_op_i            (s1_op),
    .s1_arch_dest_i     (s1_arch_dest),
    .s1_pdest_i         (s1_pdest),
    .excp_valid_i       (excp_valid),
    .ecode_i            (ecode),
    .rob_valid_o        (rob_valid_o),
    .rob_pc_o           (rob_pc_o),
    .rob_type_o         (rob_type_o),
    .rob_arch_dest_o    (rob_arch_dest_o),
    .rob_pdest_o        (rob_pdest_o),
    .rob_excp_valid_o   (rob_excp_valid_o),
    .rob_ecode_o        (rob_ecode_o),
    .issue_valid_o      (issue_valid_o),
    .issue_pc_o         (issue_pc_o),
    .issue_op_o         (issue_op_o),
    .issue_pdest_o      (issue_pdest_o),
    .issue_dest_valid_o (issue_dest_valid_o)
  );

endmodule

`default_nettype wire

//--- dv/sched_props.sv
// ===========================================================================
// concurrent checks on the record and issue outputs
// bound into issue_route from the testbench
// ===========================================================================

`timescale 1ns/1ps
`default_nettype none

module sched_props import sched_pkg::*; (
  input logic                clk,
  input logic                rst_n,
  input logic                rob_valid_i,
  input logic                rob_excp_valid_i,
  input logic [UNIT_NUM-1:0] issue_valid_i
);

  // one unit class per instruction at most
  issue_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(issue_valid_i))
    else $error("more than one issue strobe high");

  // an issue always travels with a clean record
  issue_has_record: assert property (@(posedge clk) disable iff (!rst_n)
    (|issue_valid_i) |-> (rob_valid_i && !rob_excp_valid_i))
    else $error("issue strobe without a matching clean record");

  excp_blocks_issue: assert property (@(posedge clk) disable iff (!rst_n)
    rob_excp_valid_i |-> (issue_valid_i == '0))
    else $error("issue strobe raised for an excepting instruction");

endmodule

`default_nettype wire

//--- dv/tb_sched.sv
// ===========================================================================
// testbench for the scheduler front end
// random requests and register returns from a fixed seed, checked against
// a model of the free list, exception priority and unit routing
// a watchdog bounds the run
// ===========================================================================

`timescale 1ns/1ps
`default_nettype none

module tb_sched import sched_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DLY    = 2;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_REQ      = 3000;
  // requests stall while the list is empty, so allow three cycles each
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 3 * NUM_REQ + 2000;

  typedef struct packed {
    int          due;
    logic [31:0] pc;
    logic [2:0]  itype;
    logic [3:0]  op;
    logic [4:0]  adest;
    logic [5:0]  pdest;
    logic        excp;
    logic [5:0]  ecode;
    logic [3:0]  issue;
    logic        dest_valid;
  } exp_rec_t;

  logic                  clk;
  logic                  rst_n;
  logic                  req_valid_i;
  logic [31:0]           req_pc_i;
  instr_type_e           req_type_i;
  op_u_t                 req_op_i;
  logic                  req_invalid_i;
  logic                  req_fetch_excp_i;
  logic [ECODE_W-1:0]    req_fetch_ecode_i;
  logic [ARCH_REG_W-1:0] req_arch_dest_i;
  logic [4:0]            req_cacop_code_i;
  logic                  csr_has_int_i;
  logic [1:0]            csr_plv_i;
  logic                  free_valid_i;
  preg_t                 free_preg_i;
  logic                  ready_o;
  logic                  rob_valid_o;
  logic [31:0]           rob_pc_o;
  instr_type_e           rob_type_o;
  logic [ARCH_REG_W-1:0] rob_arch_dest_o;
  preg_t                 rob_pdest_o;
  logic                  rob_excp_valid_o;
  logic [ECODE_W-1:0]    rob_ecode_o;
  logic [UNIT_NUM-1:0]   issue_valid_o;
  logic [31:0]           issue_pc_o;
  op_u_t                 issue_op_o;
  preg_t                 issue_pdest_o;
  logic                  issue_dest_valid_o;

  // model state
  exp_rec_t    exp_q[$];
  preg_t       free_model[$];
  preg_t       alloc_list[$];
  logic [31:0] rng_state = 32'h4fa9b213;
  logic [31:0] next_pc   = 32'h1c00_0000;
  int          cyc       = 0;
  int          sent      = 0;
  int          checked   = 0;

  sched_top uut (
    .clk (clk), .rst_n (rst_n),
    .req_valid_i (req_valid_i), .req_pc_i (req_pc_i), .req_type_i (req_type_i),
    .req_op_i (req_op_i), .req_invalid_i (req_invalid_i),
    .req_fetch_excp_i (req_fetch_excp_i), .req_fetch_ecode_i (req_fetch_ecode_i),
    .req_arch_dest_i (req_arch_dest_i), .req_cacop_code_i (req_cacop_code_i),
    .csr_has_int_i (csr_has_int_i), .csr_plv_i (csr_plv_i),
    .free_valid_i (free_valid_i), .free_preg_i (free_preg_i), .ready_o (ready_o),
    .rob_valid_o (rob_valid_o), .rob_pc_o (rob_pc_o), .rob_type_o (rob_type_o),
    .rob_arch_dest_o (rob_arch_dest_o), .rob_pdest_o (rob_pdest_o),
    .rob_excp_valid_o (rob_excp_valid_o), .rob_ecode_o (rob_ecode_o),
    .issue_valid_o (issue_valid_o), .issue_pc_o (issue_pc_o),
    .issue_op_o (issue_op_o), .issue_pdest_o (issue_pdest_o),
    .issue_dest_valid_o (issue_dest_valid_o)
  );

  bind issue_route sched_props u_props (
    .clk              (clk),
    .rst_n            (rst_n),
    .rob_valid_i      (rob_valid_o),
    .rob_excp_valid_i (rob_excp_valid_o),
    .issue_valid_i    (issue_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired: the test did not finish in the allowed time");
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  end

  task automatic fail_check(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first mismatch");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] draw();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // returns {valid, code} in priority order
  function automatic logic [6:0] predict_exception(
    input logic [2:0] itype, input logic [3:0] op, input logic inval,
    input logic fexcp, input logic [5:0] fcode, input logic [4:0] cacop,
    input logic hint, input logic [1:0] plv);
    logic needs_priv;
    needs_priv = (itype == INSTR_PRIV) ||
                 (itype == INSTR_MEM && op == MEM_OP_CACOP && cacop[4:3] != 2'd2);
    if (hint) return {1'b1, ECODE_INT};
    if (fexcp) return {1'b1, fcode};
    if (inval) return {1'b1, ECODE_INE};
    if (needs_priv && plv == 2'd3) return {1'b1, ECODE_IPE};
    if (itype == INSTR_MISC && op == MISC_OP_SYSCALL) return {1'b1, ECODE_SYS};
    if (itype == INSTR_MISC && op == MISC_OP_BREAK) return {1'b1, ECODE_BRK};
    return 7'd0;
  endfunction

  function automatic logic [3:0] expected_issue_bits(input logic [2:0] itype);
    case (itype)
      INSTR_ALU: return 4'b0001;
      INSTR_MDU: return 4'b0010;
      INSTR_MEM: return 4'b0100;
      default:   return 4'b1000;
    endcase
  endfunction

  // ========================================================================
  // one clock of stimulus
  // req_mode 0 idle, 1 random, 2 always allocating
  // free_mode 0 none, 1 random, 2 always when something is allocated
  // ========================================================================
  task automatic run_cycle(input int req_mode, input int free_mode);
    logic [31:0] r;
    logic [31:0] s;
    logic [2:0]  itype;
    logic [3:0]  op;
    logic [4:0]  adest;
    logic [6:0]  excp;
    logic        fexcp;
    logic        inval;
    logic        hint;
    logic        freeing;
    preg_t       freed;
    preg_t       pdest;
    int          idx;
    exp_rec_t    rec;
    @(posedge clk);
    #DRIVE_DLY;
    assert (ready_o == (free_model.size() != 0))
      else fail_check($sformatf("ready_o %0b with %0d free in model", ready_o,
                                free_model.size()));
    req_valid_i  = 1'b0;
    free_valid_i = 1'b0;
    freeing      = 1'b0;
    freed        = '0;
    r = draw();
    // pick the return first so a register is not freed in its own cycle
    if (alloc_list.size() != 0 && (free_mode == 2 || (free_mode == 1 && r[0]))) begin
      idx = int'(draw() % 32'(alloc_list.size()));
      freed = alloc_list[idx];
      alloc_list.delete(idx);
      freeing = 1'b1;
      free_valid_i = 1'b1;
      free_preg_i = freed;
    end
    if (ready_o && (req_mode == 2 || (req_mode == 1 && r[2:1] != 2'b00))) begin
      r = draw();
      s = draw();
      itype = (req_mode == 2) ? 3'(INSTR_ALU) : 3'(r[7:0] % 8'd6);
      case (itype)
        INSTR_ALU:  op = r[11:8] % 4'd12;
        INSTR_MEM:  op = r[12] ? 4'(MEM_OP_CACOP) : r[11:8] % 4'd14;
        INSTR_MISC: op = {2'b00, r[9:8]};
        INSTR_BR:   op = 4'd5 + {1'b0, r[10:8] % 3'd5};
        default:    op = r[11:8];
      endcase
      fexcp = (req_mode == 1) && (r[15:13] == 3'd0) && r[16];
      inval = (req_mode == 1) && (r[19:17] == 3'd0) && r[31];
      hint  = (req_mode == 1) && (r[30:26] < 5'd2);
      if (req_mode == 2) adest = s[7:3] | 5'd1;
      else adest = (s[2:0] == 3'd0) ? 5'd0 : s[7:3];
      req_valid_i       = 1'b1;
      req_pc_i          = next_pc;
      req_type_i        = instr_type_e'(itype);
      req_op_i          = op;
      req_invalid_i     = inval;
      req_fetch_excp_i  = fexcp;
      req_fetch_ecode_i = r[25:20];
      req_arch_dest_i   = adest;
      req_cacop_code_i  = s[12:8];
      csr_has_int_i     = hint;
      csr_plv_i         = s[14:13];
      excp = predict_exception(itype, op, inval, fexcp, r[25:20], s[12:8], hint, s[14:13]);
      pdest = '0;
      if (!fexcp && !inval && adest != 5'd0) begin
        pdest = free_model.pop_front();
        alloc_list.push_back(pdest);
      end
      rec.due        = cyc + 2;
      rec.pc         = next_pc;
      rec.itype      = itype;
      rec.op         = op;
      rec.adest      = adest;
      rec.pdest      = pdest;
      rec.excp       = excp[6];
      rec.ecode      = excp[5:0];
      rec.issue      = excp[6] ? 4'b0000 : expected_issue_bits(itype);
      rec.dest_valid = (adest != 5'd0);
      exp_q.push_back(rec);
      next_pc = next_pc + 32'd4;
      sent++;
    end
    if (freeing) free_model.push_back(freed);
  endtask

  // ========================================================================
  // output checks, sampled mid-cycle where registered outputs are stable
  // ========================================================================
  always @(negedge clk) begin
    exp_rec_t rec;
    if (cyc != 0) begin
      if (rob_valid_o) begin
        assert (exp_q.size() != 0) else fail_check("record appeared with no request pending");
        rec = exp_q.pop_front();
        assert (rec.due == cyc)
          else fail_check($sformatf("record pc %08h in cycle %0d, expected cycle %0d",
                                    rec.pc, cyc, rec.due));
        assert (rob_pc_o == rec.pc)
          else fail_check($sformatf("rob_pc_o %08h expected %08h", rob_pc_o, rec.pc));
        assert (rob_type_o == rec.itype)
          else fail_check($sformatf("rob_type_o %0d expected %0d", rob_type_o, rec.itype));
        assert (rob_arch_dest_o == rec.adest)
          else fail_check($sformatf("rob_arch_dest_o %0d expected %0d", rob_arch_dest_o,
                                    rec.adest));
        assert (rob_pdest_o == rec.pdest)
          else fail_check($sformatf("rob_pdest_o %0d expected %0d", rob_pdest_o, rec.pdest));
        assert (rob_excp_valid_o == rec.excp)
          else fail_check($sformatf("rob_excp_valid_o %0b expected %0b at pc %08h",
                                    rob_excp_valid_o, rec.excp, rec.pc));
        if (rec.excp) begin
          assert (rob_ecode_o == rec.ecode)
            else fail_check($sformatf("rob_ecode_o %02h expected %02h", rob_ecode_o,
                                      rec.ecode));
        end
        assert (issue_valid_o == rec.issue)
          else fail_check($sformatf("issue_valid_o %04b expected %04b", issue_valid_o,
                                    rec.issue));
        if (rec.issue != 4'b0000) begin
          assert (issue_pc_o == rec.pc)
            else fail_check($sformatf("issue_pc_o %08h expected %08h", issue_pc_o, rec.pc));
          assert (issue_op_o == rec.op)
            else fail_check($sformatf("issue_op_o %0h expected %0h", issue_op_o, rec.op));
          assert (issue_pdest_o == rec.pdest)
            else fail_check($sformatf("issue_pdest_o %0d expected %0d", issue_pdest_o,
                                      rec.pdest));
          assert (issue_dest_valid_o == rec.dest_valid)
            else fail_check("issue_dest_valid_o does not match the destination");
        end
        checked++;
      end else begin
        assert (exp_q.size() == 0 || exp_q[0].due != cyc)
          else fail_check($sformatf("no record for pc %08h", exp_q[0].pc));
        assert (issue_valid_o == '0) else fail_check("issue strobe without a record");
      end
    end
  end

  initial begin
    rst_n             = 1'b0;
    req_valid_i       = 1'b0;
    req_pc_i          = '0;
    req_type_i        = INSTR_ALU;
    req_op_i          = '0;
    req_invalid_i     = 1'b0;
    req_fetch_excp_i  = 1'b0;
    req_fetch_ecode_i = '0;
    req_arch_dest_i   = '0;
    req_cacop_code_i  = '0;
    csr_has_int_i     = 1'b0;
    csr_plv_i         = '0;
    free_valid_i      = 1'b0;
    free_preg_i       = '0;
    for (int i = 0; i < FREE_DEPTH; i++) begin
      free_model.push_back(preg_t'(32 + i));
    end
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #DRIVE_DLY;
      assert (ready_o) else fail_check("ready_o low during reset");
    end
    rst_n = 1'b1;
    repeat (4) run_cycle(0, 0);
    while (sent < NUM_REQ) run_cycle(1, 1);
    // drain the list with returns held off, then one return reopens it
    while (free_model.size() != 0) run_cycle(2, 0);
    repeat (3) run_cycle(0, 0);
    run_cycle(0, 2);
    run_cycle(2, 0);
    while (alloc_list.size() != 0) run_cycle(0, 2);
    while (exp_q.size() != 0) run_cycle(0, 0);
    repeat (3) run_cycle(0, 0);
    $display("%0d records checked", checked);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
design/sched_pkg.sv
design/phys_free_list.sv
design/alloc_stage.sv
design/excp_check.sv
design/issue_route.sv
design/sched_top.sv
dv/sched_props.sv
dv/tb_sched.sv

//--- run.sh
#!/bin/sh
# build the scheduler testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_sched -f build.f -o Vtb_sched
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_sched 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
